// ==== include/rvv_lite_consts.svh ====
`ifndef RVV_LITE_CONSTS_SVH
`define RVV_LITE_CONSTS_SVH

// Vector register geometry
`define RVV_VLEN        64
`define RVV_SEW         8
`define RVV_NUM_ELEM    8
`define RVV_NUM_VREG    8
`define RVV_VREG_IDX_W  3

// Command queue depth and the sender's starting credit count
`define RVV_CQ_DEPTH    4

// ALU reservation station
`define RVV_RS_DEPTH    2

// Reorder buffer
`define RVV_ROB_DEPTH   4
`define RVV_ROB_IDX_W   2

`endif

// ==== src/rvv_lite_pkg.sv ====
`default_nettype none

`include "rvv_lite_consts.svh"

package rvv_lite_pkg;

    typedef enum logic [1:0] {
        OP_VADD_VV = 2'd0,
        OP_VSUB_VV = 2'd1,
        OP_VADD_VX = 2'd2
    } rvv_op_e;

    // Instruction as accepted from the frontend
    typedef struct packed {
        rvv_op_e                     op;
        logic [`RVV_VREG_IDX_W-1:0]  vd;
        logic [`RVV_VREG_IDX_W-1:0]  vs1;
        logic [`RVV_VREG_IDX_W-1:0]  vs2;
        logic [`RVV_SEW-1:0]         scalar;
    } rvv_cmd_t;

    // Issued uop with operands already read
    typedef struct packed {
        rvv_op_e                     op;
        logic [`RVV_ROB_IDX_W-1:0]   rob_idx;
        logic [`RVV_VLEN-1:0]        src_a;
        logic [`RVV_VLEN-1:0]        src_b;
        logic [`RVV_SEW-1:0]         scalar;
    } alu_uop_t;

    typedef struct packed {
        logic [`RVV_ROB_IDX_W-1:0]   rob_idx;
        logic [`RVV_VLEN-1:0]        data;
    } alu_res_t;

    // Retired register write
    typedef struct packed {
        logic [`RVV_VREG_IDX_W-1:0]  vd;
        logic [`RVV_VLEN-1:0]        data;
    } rt_t;

endpackage

`default_nettype wire

// ==== src/rvv_lite_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_lite_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic push,
    input  wire T     in_data,
    input  wire logic pop,
    output T          out_data,
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wraps at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    // Head is shown without a read cycle
    assign out_data = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    // Producers and consumers must respect the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty));

endmodule

`default_nettype wire

// ==== src/rvv_lite_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_lite_consts.svh"

module rvv_lite_dispatch import rvv_lite_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire rvv_cmd_t                    cq_head,
    input  wire logic                        cq_empty,
    output logic                             cq_pop,
    output logic [`RVV_VREG_IDX_W-1:0]       rd_idx_a,
    output logic [`RVV_VREG_IDX_W-1:0]       rd_idx_b,
    input  wire logic [`RVV_VLEN-1:0]        rd_data_a,
    input  wire logic [`RVV_VLEN-1:0]        rd_data_b,
    input  wire logic                        rob_full,
    input  wire logic [`RVV_ROB_IDX_W-1:0]   rob_idx,
    output logic                             alloc,
    output logic [`RVV_VREG_IDX_W-1:0]       alloc_vd,
    input  wire logic                        rs_full,
    output logic                             rs_push,
    output alu_uop_t                         rs_uop,
    input  wire logic                        rt_valid,
    input  wire logic [`RVV_VREG_IDX_W-1:0]  rt_vd
);

    // One bit per register with a write still in flight
    logic [`RVV_NUM_VREG-1:0] busy;
    logic                     vs1_used;
    logic                     hazard;
    logic                     issue;

    always_comb begin
        vs1_used = (cq_head.op != OP_VADD_VX);
        // RAW on the sources, WAW on vd
        hazard   = busy[cq_head.vs2] | busy[cq_head.vd] | (vs1_used & busy[cq_head.vs1]);
        issue    = !cq_empty && !hazard && !rob_full && !rs_full;
    end

    assign cq_pop   = issue;
    assign rs_push  = issue;
    assign alloc    = issue;
    assign alloc_vd = cq_head.vd;

    // Port A carries vs2, port B carries vs1
    assign rd_idx_a = cq_head.vs2;
    assign rd_idx_b = cq_head.vs1;

    always_comb begin
        rs_uop.op      = cq_head.op;
        rs_uop.rob_idx = rob_idx;
        rs_uop.src_a   = rd_data_a;
        rs_uop.src_b   = vs1_used ? rd_data_b : '0;
        rs_uop.scalar  = cq_head.scalar;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (rt_valid)
                busy[rt_vd] <= 1'b0;
            if (issue)
                busy[cq_head.vd] <= 1'b1;
        end
    end

    // A retire from the ROB always belongs to a register marked busy here
    a_retire_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid |-> busy[rt_vd]);

endmodule

`default_nettype wire

// ==== src/rvv_lite_vrf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_lite_consts.svh"

module rvv_lite_vrf import rvv_lite_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`RVV_VREG_IDX_W-1:0]  rd_idx_a,
    input  wire logic [`RVV_VREG_IDX_W-1:0]  rd_idx_b,
    output logic [`RVV_VLEN-1:0]             rd_data_a,
    output logic [`RVV_VLEN-1:0]             rd_data_b,
    input  wire logic                        wr_valid,
    input  wire rt_t                         wr
);

    logic [`RVV_VLEN-1:0] regs [`RVV_NUM_VREG];

    // Element e of register r starts at r*16 + e
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `RVV_NUM_VREG; r++)
                for (int e = 0; e < `RVV_NUM_ELEM; e++)
                    regs[r][e*`RVV_SEW +: `RVV_SEW] <= `RVV_SEW'(r * 16 + e);
        end else if (wr_valid) begin
            regs[wr.vd] <= wr.data;
        end
    end

    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== src/rvv_lite_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_lite_consts.svh"

module rvv_lite_alu import rvv_lite_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     rs_empty,
    output logic          rs_pop,
    input  wire alu_uop_t uop,
    output logic          res_valid,
    output alu_res_t      res
);

    logic [`RVV_VLEN-1:0] result;

    // Single cycle unit, never stalls
    assign rs_pop = !rs_empty;

    always_comb begin
        logic [`RVV_SEW-1:0] a;
        logic [`RVV_SEW-1:0] b;
        result = '0;
        for (int e = 0; e < `RVV_NUM_ELEM; e++) begin
            a = uop.src_a[e*`RVV_SEW +: `RVV_SEW];
            b = uop.src_b[e*`RVV_SEW +: `RVV_SEW];
            // Element sums wrap modulo 256
            case (uop.op)
                OP_VSUB_VV: result[e*`RVV_SEW +: `RVV_SEW] = a - b;
                OP_VADD_VX: result[e*`RVV_SEW +: `RVV_SEW] = a + uop.scalar;
                default:    result[e*`RVV_SEW +: `RVV_SEW] = a + b;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= rs_pop;
    end

    always_ff @(posedge clk) begin
        if (rs_pop) begin
            res.rob_idx <= uop.rob_idx;
            res.data    <= result;
        end
    end

endmodule

`default_nettype wire

// ==== src/rvv_lite_rob.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_lite_consts.svh"

module rvv_lite_rob import rvv_lite_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        alloc,
    input  wire logic [`RVV_VREG_IDX_W-1:0]  alloc_vd,
    output logic                             rob_full,
    output logic [`RVV_ROB_IDX_W-1:0]        rob_idx,
    input  wire logic                        res_valid,
    input  wire alu_res_t                    res,
    output logic                             rt_valid,
    output rt_t                              rt
);

    localparam int CNT_W = `RVV_ROB_IDX_W + 1;

    logic [`RVV_ROB_DEPTH-1:0]  valid_q;
    logic [`RVV_ROB_DEPTH-1:0]  done_q;
    logic [`RVV_VREG_IDX_W-1:0] vd_q   [`RVV_ROB_DEPTH];
    logic [`RVV_VLEN-1:0]       data_q [`RVV_ROB_DEPTH];
    logic [`RVV_ROB_IDX_W-1:0]  head_q;
    logic [`RVV_ROB_IDX_W-1:0]  tail_q;
    logic [CNT_W-1:0]           count_q;

    assign rob_full = (count_q == CNT_W'(`RVV_ROB_DEPTH));
    assign rob_idx  = tail_q;

    // Only the oldest entry may leave
    assign rt_valid = valid_q[head_q] & done_q[head_q];
    assign rt.vd    = vd_q[head_q];
    assign rt.data  = data_q[head_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (res_valid)
                done_q[res.rob_idx] <= 1'b1;
            if (rt_valid) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(alloc) - CNT_W'(rt_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            vd_q[tail_q] <= alloc_vd;
        if (res_valid)
            data_q[res.rob_idx] <= res.data;
    end

    // ALU results land only on allocated entries still waiting
    a_res_allocated: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (valid_q[res.rob_idx] && !done_q[res.rob_idx]));

endmodule

`default_nettype wire

// ==== src/rvv_lite_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_lite_consts.svh"

module rvv_lite_top import rvv_lite_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     cmd_valid,
    input  wire rvv_cmd_t cmd,
    output logic          cmd_credit,
    output logic          rt_valid,
    output rt_t           rt
);

    rvv_cmd_t                   cq_head;
    logic                       cq_empty;
    logic                       cq_pop;
    logic [`RVV_VREG_IDX_W-1:0] rd_idx_a;
    logic [`RVV_VREG_IDX_W-1:0] rd_idx_b;
    logic [`RVV_VLEN-1:0]       rd_data_a;
    logic [`RVV_VLEN-1:0]       rd_data_b;
    logic                       rob_full;
    logic [`RVV_ROB_IDX_W-1:0]  rob_idx;
    logic                       alloc;
    logic [`RVV_VREG_IDX_W-1:0] alloc_vd;
    logic                       rs_full;
    logic                       rs_push;
    alu_uop_t                   rs_uop;
    logic                       rs_empty;
    logic                       rs_pop;
    alu_uop_t                   rs_head;
    logic                       res_valid;
    alu_res_t                   res;

    // Each pop frees a slot and hands one credit back
    assign cmd_credit = cq_pop;

    // Credits keep the sender from overrunning the queue
    rvv_lite_fifo #(
        .T     (rvv_cmd_t),
        .DEPTH (`RVV_CQ_DEPTH)
    ) cmd_queue_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (cmd_valid),
        .in_data  (cmd),
        .pop      (cq_pop),
        .out_data (cq_head),
        .empty    (cq_empty),
        .full     ()
    );

    rvv_lite_dispatch dispatch_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cq_head   (cq_head),
        .cq_empty  (cq_empty),
        .cq_pop    (cq_pop),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rob_full  (rob_full),
        .rob_idx   (rob_idx),
        .alloc     (alloc),
        .alloc_vd  (alloc_vd),
        .rs_full   (rs_full),
        .rs_push   (rs_push),
        .rs_uop    (rs_uop),
        .rt_valid  (rt_valid),
        .rt_vd     (rt.vd)
    );

    rvv_lite_vrf vrf_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_valid  (rt_valid),
        .wr        (rt)
    );

    // ALU reservation station
    rvv_lite_fifo #(
        .T     (alu_uop_t),
        .DEPTH (`RVV_RS_DEPTH)
    ) alu_rs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (rs_push),
        .in_data  (rs_uop),
        .pop      (rs_pop),
        .out_data (rs_head),
        .empty    (rs_empty),
        .full     (rs_full)
    );

    rvv_lite_alu alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs_empty  (rs_empty),
        .rs_pop    (rs_pop),
        .uop       (rs_head),
        .res_valid (res_valid),
        .res       (res)
    );

    rvv_lite_rob rob_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc),
        .alloc_vd  (alloc_vd),
        .rob_full  (rob_full),
        .rob_idx   (rob_idx),
        .res_valid (res_valid),
        .res       (res),
        .rt_valid  (rt_valid),
        .rt        (rt)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RST_CYCLES  = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/tb_rvv_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvv_lite_consts.svh"

module tb_rvv_lite import rvv_lite_pkg::*; ();

    localparam int RST_CYCLES       = 8;
    localparam int CLK_PERIOD       = 8;
    localparam int CYCLES_PER_ENTRY = 20;
    localparam int NUM_RANDOM       = 40;

    logic     clk;
    logic     rst_n;
    logic     cmd_valid;
    rvv_cmd_t cmd;
    logic     cmd_credit;
    logic     rt_valid;
    rt_t      rt;

    // Stimulus table with one expected retire per command
    string    tab_name[$];
    rvv_cmd_t tab_cmd[$];
    rt_t      tab_exp[$];

    logic [`RVV_VLEN-1:0] ref_regs [`RVV_NUM_VREG];

    int credits;
    int sent;
    int returned;
    int idx;
    int retired;
    int zero_credit_waits;
    int rt_errors;
    int flow_errors;
    bit table_ready;

    tb_clk_gen #(
        .HALF_PERIOD (CLK_PERIOD / 2),
        .RST_CYCLES  (RST_CYCLES)
    ) clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rvv_lite_top rvv_lite_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rt_valid   (rt_valid),
        .rt         (rt)
    );

    task automatic compare_rt(input string name, input rt_t exp, input rt_t act);
        if (act !== exp) begin
            rt_errors++;
            $display("ERR %s: expected vd %0d data %h, actual vd %0d data %h",
                     name, exp.vd, exp.data, act.vd, act.data);
        end
    endtask

    task automatic compare_credit(input string name, input int exp, input int act);
        if (act != exp) begin
            flow_errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flow_errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Element e of register r holds r*16 + e out of reset
    task automatic reset_model();
        for (int r = 0; r < `RVV_NUM_VREG; r++)
            for (int e = 0; e < `RVV_NUM_ELEM; e++)
                ref_regs[r][e*`RVV_SEW +: `RVV_SEW] = `RVV_SEW'(r * 16 + e);
    endtask

    // First operand is always vs2 and the second is vs1 or the scalar
    task automatic model_step(input rvv_cmd_t c, output rt_t w);
        logic [`RVV_SEW-1:0] a;
        logic [`RVV_SEW-1:0] b;
        w.vd   = c.vd;
        w.data = '0;
        for (int e = 0; e < `RVV_NUM_ELEM; e++) begin
            a = ref_regs[c.vs2][e*`RVV_SEW +: `RVV_SEW];
            b = (c.op == OP_VADD_VX) ? c.scalar : ref_regs[c.vs1][e*`RVV_SEW +: `RVV_SEW];
            w.data[e*`RVV_SEW +: `RVV_SEW] = (c.op == OP_VSUB_VV) ? a - b : a + b;
        end
        ref_regs[c.vd] = w.data;
    endtask

    task automatic add_entry(input string name, input rvv_op_e op, input int vd,
                             input int vs1, input int vs2, input int scalar);
        rvv_cmd_t c;
        rt_t      w;
        c.op     = op;
        c.vd     = `RVV_VREG_IDX_W'(vd);
        c.vs1    = `RVV_VREG_IDX_W'(vs1);
        c.vs2    = `RVV_VREG_IDX_W'(vs2);
        c.scalar = `RVV_SEW'(scalar);
        model_step(c, w);
        tab_name.push_back(name);
        tab_cmd.push_back(c);
        tab_exp.push_back(w);
    endtask

    task automatic build_table();
        logic [1:0] op_bits;
        reset_model();
        // Independent destinations
        add_entry("add_indep_0", OP_VADD_VV, 4, 1, 2, 0);
        add_entry("add_indep_1", OP_VADD_VV, 5, 2, 3, 0);
        add_entry("add_indep_2", OP_VADD_VV, 6, 3, 7, 0);
        add_entry("add_indep_3", OP_VADD_VV, 0, 7, 1, 0);
        // Each reads the previous destination
        add_entry("chain_0", OP_VADD_VV, 1, 4, 5, 0);
        add_entry("chain_1", OP_VADD_VV, 2, 1, 1, 0);
        add_entry("chain_2", OP_VSUB_VV, 3, 1, 2, 0);
        add_entry("rewrite_0", OP_VADD_VX, 3, 0, 3, 1);
        add_entry("rewrite_1", OP_VADD_VV, 3, 3, 3, 0);
        add_entry("rewrite_2", OP_VSUB_VV, 3, 0, 3, 0);
        // Wrap around 0 and 255
        add_entry("sub_self_zero", OP_VSUB_VV, 5, 6, 6, 0);
        add_entry("sub_below_zero", OP_VSUB_VV, 4, 7, 5, 0);
        add_entry("vx_add_ff", OP_VADD_VX, 6, 0, 4, 255);
        add_entry("vx_add_80", OP_VADD_VX, 7, 0, 7, 128);
        add_entry("vx_zero_plus_ff", OP_VADD_VX, 2, 0, 5, 255);
        // Dependent burst drains the credits
        for (int i = 0; i < `RVV_CQ_DEPTH; i++)
            add_entry($sformatf("burst_%0d", i), OP_VADD_VX, 1, 0, 1, 3);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op_bits = 2'($urandom % 3);
            add_entry($sformatf("rand_%0d", i), rvv_op_e'(op_bits), int'($urandom % 8),
                      int'($urandom % 8), int'($urandom % 8), int'($urandom % 256));
        end
    endtask

    // One sender cycle spends a credit on a send and regains one on a pulse
    task automatic drive_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
        if (idx < tab_cmd.size()) begin
            if (credits > 0) begin
                cmd_valid = 1'b1;
                cmd       = tab_cmd[idx];
                idx++;
                credits--;
                sent++;
            end else begin
                zero_credit_waits++;
            end
        end
        // The pulse frees its slot at the coming edge for use next cycle
        if (cmd_credit) begin
            credits++;
            returned++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && rt_valid) begin
            if (retired < tab_exp.size()) begin
                compare_rt(tab_name[retired], tab_exp[retired], rt);
            end else begin
                flow_errors++;
                $display("Retire of vd %0d with no command left to match it", rt.vd);
            end
            retired++;
        end
    end

    initial begin
        cmd_valid         = 1'b0;
        cmd               = '0;
        credits           = `RVV_CQ_DEPTH;
        sent              = 0;
        returned          = 0;
        idx               = 0;
        retired           = 0;
        zero_credit_waits = 0;
        rt_errors         = 0;
        flow_errors       = 0;
        void'($urandom(32'hd765));
        build_table();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        // Nothing moves before the first send
        repeat (3) begin
            @(negedge clk);
            compare_flag("idle_cmd_credit", 1'b0, cmd_credit);
            compare_flag("idle_rt_valid", 1'b0, rt_valid);
        end
        while (idx < tab_cmd.size() || retired < tab_cmd.size())
            drive_cycle();
        repeat (4) drive_cycle();
        compare_credit("credits_returned", sent, returned);
        compare_credit("credits_held", `RVV_CQ_DEPTH, credits);
        if (zero_credit_waits == 0) begin
            flow_errors++;
            $display("Credits never ran out, so the sender was never throttled");
        end
        $display("Errors: retire %0d, flow %0d", rt_errors, flow_errors);
        if (rt_errors == 0 && flow_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (tab_cmd.size() * CYCLES_PER_ENTRY + RST_CYCLES) @(posedge clk);
        $display("Timeout with %0d of %0d commands retired", retired, tab_cmd.size());
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvv_lite.f ====
+incdir+include
src/rvv_lite_pkg.sv
src/rvv_lite_fifo.sv
src/rvv_lite_dispatch.sv
src/rvv_lite_vrf.sv
src/rvv_lite_alu.sv
src/rvv_lite_rob.sv
src/rvv_lite_top.sv
dv/tb_clk_gen.sv
dv/tb_rvv_lite.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rvv_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rvv_lite -f rvv_lite.f --Mdir obj_dir -o sim_rvv_lite
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_rvv_lite)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
